//--- source/isp_pixel_pkg.sv
package isp_pixel_pkg;

    // ------------------------------
    // picture geometry
    // ------------------------------
    localparam int PIXELS_PER_BEAT   = 16;
    localparam int BEATS_PER_CHANNEL = 64;
    localparam int BEATS_PER_PIC     = 3 * BEATS_PER_CHANNEL;

    // gray sum of 1024 pixels per channel, scaled down to 0..255
    localparam int AVG_SHIFT = 10;

    // ------------------------------
    // pixel and beat types
    // ------------------------------
    typedef logic [7:0] pixel_t;

    // msb view for the doubling saturation test
    typedef struct packed {
        logic       sat_bit;
        logic [6:0] low7;
    } pixel_bits_t;

    typedef union packed {
        pixel_t      value;
        pixel_bits_t bits;
    } pixel_u;

    // pixel 0 in the low byte
    typedef pixel_u [PIXELS_PER_BEAT-1:0] beat_t;

    // worst case 1024 * (63 + 127 + 63) still fits in 18 bits
    typedef logic [17:0] gray_sum_t;

endpackage

//--- source/isp_ctrl_pkg.sv
package isp_ctrl_pkg;

    // ------------------------------
    // request fields
    // ------------------------------
    typedef enum logic [1:0] {
        RATIO_QUARTER = 2'd0,
        RATIO_HALF    = 2'd1,
        RATIO_KEEP    = 2'd2,
        RATIO_DOUBLE  = 2'd3
    } ratio_e;

    typedef logic [3:0] pic_id_t;

    // ------------------------------
    // exposure bookkeeping
    // ------------------------------
    // per picture, 0..8
    typedef logic [3:0] expo_cnt_t;

    localparam expo_cnt_t EXPO_CNT_MAX = 4'd8;

    // answer without running the datapath
    typedef enum logic [1:0] {
        REPLY_NONE   = 2'd0,
        REPLY_ZERO   = 2'd1,
        REPLY_CACHED = 2'd2
    } reply_e;

endpackage

//--- source/exposure_job_if.sv
`timescale 1ns/1ns

interface exposure_job_if;
    import isp_ctrl_pkg::*;
    import isp_pixel_pkg::*;

    // one job at a time
    logic    start;
    pic_id_t pic;
    ratio_e  ratio;
    reply_e  reply;

    // from the datapath
    logic    done;
    pixel_t  average;

    modport decode (
        output start,
        output pic,
        output ratio,
        output reply,
        input  done
    );

    modport execute (
        input  start,
        input  ratio,
        output done,
        output average
    );

    modport result (
        input pic,
        input reply,
        input done,
        input average
    );

endinterface

//--- source/isp_request_decode.sv
`timescale 1ns/1ns

module isp_request_decode #(
    parameter int          NUM_PICS   = 16,
    parameter logic [31:0] BASE_ADDR  = 32'h10000,
    parameter int          PIC_STRIDE = 3072
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  isp_ctrl_pkg::pic_id_t  in_pic_no,
    input  isp_ctrl_pkg::ratio_e   in_ratio_mode,
    input  logic                   cache_valid,
    input  logic                   rd_req_ready,
    output logic                   rd_req_valid,
    output logic [31:0]            rd_addr,
    exposure_job_if.decode         job
);
    import isp_ctrl_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECIDE,
        ST_BUSY
    } state_e;

    state_e     state;
    expo_cnt_t  expo_cnt [NUM_PICS];
    expo_cnt_t  cur_cnt;
    expo_cnt_t  next_cnt;
    logic [4:0] cnt_sum;
    logic       zero_hit;

    assign cur_cnt = expo_cnt[job.pic];

    // clamp(cnt - 2 + ratio) to 0..8
    always_comb begin
        cnt_sum = 5'(cur_cnt) + 5'(job.ratio);
        if (cnt_sum < 5'd2) begin
            next_cnt = '0;
        end else if (cnt_sum - 5'd2 > 5'(EXPO_CNT_MAX)) begin
            next_cnt = EXPO_CNT_MAX;
        end else begin
            next_cnt = 4'(cnt_sum - 5'd2);
        end
    end

    // picture would come out black anyway
    assign zero_hit = (cur_cnt == 4'd0) ||
                      (cur_cnt == 4'd1 && (job.ratio == RATIO_QUARTER ||
                                           job.ratio == RATIO_HALF)) ||
                      (cur_cnt == 4'd2 && job.ratio == RATIO_QUARTER);

    // ------------------------------
    // controller and counter table
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            job.start <= 1'b0;
            job.reply <= REPLY_NONE;
            job.pic   <= '0;
            job.ratio <= RATIO_KEEP;
            for (int i = 0; i < NUM_PICS; i++) begin
                expo_cnt[i] <= EXPO_CNT_MAX;
            end
        end else begin
            job.start <= 1'b0;
            job.reply <= REPLY_NONE;
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        job.pic   <= in_pic_no;
                        job.ratio <= in_ratio_mode;
                        state     <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    // a counter at 0 stays there
                    if (cur_cnt != 4'd0) begin
                        expo_cnt[job.pic] <= next_cnt;
                    end
                    if (zero_hit) begin
                        job.reply <= REPLY_ZERO;
                        state     <= ST_IDLE;
                    end else if (job.ratio == RATIO_KEEP && cache_valid) begin
                        job.reply <= REPLY_CACHED;
                        state     <= ST_IDLE;
                    end else begin
                        job.start <= 1'b1;
                        state     <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (job.done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------
    // read request
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_req_valid <= 1'b0;
        end else if (job.start) begin
            rd_req_valid <= 1'b1;
        end else if (rd_req_ready) begin
            rd_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DECIDE) begin
            rd_addr <= BASE_ADDR + 32'(job.pic) * 32'(PIC_STRIDE);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_addr));

endmodule

//--- source/isp_exposure_datapath.sv
`timescale 1ns/1ns

module isp_exposure_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_valid,
    input  isp_pixel_pkg::beat_t  rd_data,
    output logic                  rd_ready,
    output logic                  wr_valid,
    output isp_pixel_pkg::beat_t  wr_data,
    output logic                  wr_last,
    input  logic                  wr_ready,
    exposure_job_if.execute       job
);
    import isp_pixel_pkg::*;
    import isp_ctrl_pkg::*;

    logic       active;
    logic [7:0] rd_cnt;
    logic       rd_fire;
    logic       wr_fire;
    logic       beat_last;
    logic       is_green;
    beat_t      scaled;
    logic [9:0] part_next [4];
    logic [9:0] s1_part [4];
    logic       s1_valid;
    logic       s1_last;
    logic [11:0] tree_sum;
    gray_sum_t  acc;
    logic       sum_ready;
    logic       wr_done;

    function automatic pixel_t scale_pixel(pixel_u p, ratio_e r);
        pixel_t res;
        case (r)
            RATIO_QUARTER: res = p.value >> 2;
            RATIO_HALF:    res = p.value >> 1;
            RATIO_KEEP:    res = p.value;
            default:       res = p.bits.sat_bit ? 8'hff : {p.bits.low7, 1'b0};
        endcase
        return res;
    endfunction

    // a full write register only drains into the writer
    assign rd_ready  = active && (!wr_valid || wr_ready);
    assign rd_fire   = rd_valid && rd_ready;
    assign wr_fire   = wr_valid && wr_ready;
    assign beat_last = (rd_cnt == 8'(BEATS_PER_PIC - 1));
    assign is_green  = (rd_cnt >= 8'(BEATS_PER_CHANNEL)) &&
                       (rd_cnt < 8'(2 * BEATS_PER_CHANNEL));

    // ------------------------------
    // scaling and write register
    // ------------------------------
    always_comb begin
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            scaled[i].value = scale_pixel(rd_data[i], job.ratio);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            rd_cnt <= '0;
        end else if (job.start) begin
            active <= 1'b1;
            rd_cnt <= '0;
        end else if (rd_fire) begin
            rd_cnt <= rd_cnt + 8'd1;
            if (beat_last) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
            wr_last  <= 1'b0;
        end else if (rd_fire) begin
            wr_valid <= 1'b1;
            wr_last  <= beat_last;
        end else if (wr_ready) begin
            wr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            wr_data <= scaled;
        end
    end

    // ------------------------------
    // gray accumulation, two stages
    // ------------------------------
    // green weighs 1/2, red and blue 1/4, truncated per pixel
    always_comb begin
        for (int g = 0; g < 4; g++) begin
            part_next[g] = '0;
            for (int k = 0; k < 4; k++) begin
                part_next[g] = part_next[g] +
                    10'(scaled[4*g+k].value >> (is_green ? 1 : 2));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= rd_fire;
            s1_last  <= rd_fire && beat_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s1_part <= part_next;
        end
    end

    assign tree_sum = 12'(s1_part[0]) + 12'(s1_part[1]) +
                      12'(s1_part[2]) + 12'(s1_part[3]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            sum_ready <= 1'b0;
            wr_done   <= 1'b0;
        end else if (job.start) begin
            acc       <= '0;
            sum_ready <= 1'b0;
            wr_done   <= 1'b0;
        end else begin
            if (s1_valid) begin
                acc <= acc + gray_sum_t'(tree_sum);
            end
            if (s1_last) begin
                sum_ready <= 1'b1;
            end else if (job.done) begin
                sum_ready <= 1'b0;
            end
            if (wr_fire && wr_last) begin
                wr_done <= 1'b1;
            end else if (job.done) begin
                wr_done <= 1'b0;
            end
        end
    end

    // finished once the sum is in and the last beat has left
    assign job.done    = sum_ready && wr_done;
    assign job.average = pixel_t'(acc >> AVG_SHIFT);

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));

endmodule

//--- source/isp_result_store.sv
`timescale 1ns/1ns

module isp_result_store #(
    parameter int NUM_PICS = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    exposure_job_if.result         job,
    output logic                   cache_valid,
    output logic                   out_valid,
    output isp_pixel_pkg::pixel_t  out_data
);
    import isp_pixel_pkg::*;
    import isp_ctrl_pkg::*;

    pixel_t              avg_mem [NUM_PICS];
    logic [NUM_PICS-1:0] avg_valid;

    assign cache_valid = avg_valid[job.pic];

    // ------------------------------
    // average cache
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avg_valid <= '0;
            for (int i = 0; i < NUM_PICS; i++) begin
                avg_mem[i] <= '0;
            end
        end else if (job.done) begin
            avg_mem[job.pic]   <= job.average;
            avg_valid[job.pic] <= 1'b1;
        end
    end

    // reply register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= job.done || (job.reply != REPLY_NONE);
            if (job.done) begin
                out_data <= job.average;
            end else if (job.reply == REPLY_CACHED) begin
                out_data <= avg_mem[job.pic];
            end else begin
                out_data <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid);

endmodule

//--- source/isp_top.sv
`timescale 1ns/1ns

module isp_top #(
    parameter int          NUM_PICS   = 16,
    parameter logic [31:0] BASE_ADDR  = 32'h10000,
    parameter int          PIC_STRIDE = 3072
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // request and reply
    input  logic                   in_valid,
    input  isp_ctrl_pkg::pic_id_t  in_pic_no,
    input  isp_ctrl_pkg::ratio_e   in_ratio_mode,
    output logic                   out_valid,
    output isp_pixel_pkg::pixel_t  out_data,

    // memory side
    output logic                   rd_req_valid,
    output logic [31:0]            rd_addr,
    input  logic                   rd_req_ready,
    input  logic                   rd_valid,
    input  isp_pixel_pkg::beat_t   rd_data,
    output logic                   rd_ready,
    output logic                   wr_valid,
    output isp_pixel_pkg::beat_t   wr_data,
    output logic                   wr_last,
    input  logic                   wr_ready
);

    logic cache_valid;

    exposure_job_if job_if ();

    isp_request_decode #(
        .NUM_PICS   (NUM_PICS),
        .BASE_ADDR  (BASE_ADDR),
        .PIC_STRIDE (PIC_STRIDE)
    ) decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .cache_valid   (cache_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_req_valid  (rd_req_valid),
        .rd_addr       (rd_addr),
        .job           (job_if.decode)
    );

    isp_exposure_datapath datapath_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_ready (rd_ready),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_last  (wr_last),
        .wr_ready (wr_ready),
        .job      (job_if.execute)
    );

    isp_result_store #(
        .NUM_PICS (NUM_PICS)
    ) result_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .job         (job_if.result),
        .cache_valid (cache_valid),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

//--- sim/isp_tb.sv
`timescale 1ns/1ns

module isp_tb;
    import isp_pixel_pkg::*;
    import isp_ctrl_pkg::*;

    localparam int          NUM_PICS       = 16;
    localparam logic [31:0] BASE_ADDR      = 32'h10000;
    localparam int          PIC_STRIDE     = 3072;
    localparam int          NUM_BEATS      = NUM_PICS * BEATS_PER_PIC;
    localparam int          NUM_ENTRIES    = 14;
    localparam int          REPLY_WAIT     = 600;
    localparam int          TIMEOUT_CYCLES = NUM_ENTRIES * 600;

    typedef struct packed {
        pic_id_t     pic;
        ratio_e      ratio;
        reply_e      kind;
        logic        stall;
        pixel_t      avg;
        logic [31:0] addr;
    } entry_t;

    // pic, ratio, reply kind, stalls; avg and addr come from the reference model
    entry_t tbl [NUM_ENTRIES] = '{
        '{4'd3,  RATIO_KEEP,    REPLY_NONE,   1'b0, 8'h00, 32'h0},
        '{4'd3,  RATIO_KEEP,    REPLY_CACHED, 1'b0, 8'h00, 32'h0},
        '{4'd5,  RATIO_QUARTER, REPLY_NONE,   1'b0, 8'h00, 32'h0},
        '{4'd7,  RATIO_HALF,    REPLY_NONE,   1'b0, 8'h00, 32'h0},
        '{4'd9,  RATIO_DOUBLE,  REPLY_NONE,   1'b0, 8'h00, 32'h0},
        '{4'd5,  RATIO_QUARTER, REPLY_NONE,   1'b0, 8'h00, 32'h0},
        '{4'd5,  RATIO_QUARTER, REPLY_NONE,   1'b0, 8'h00, 32'h0},
        '{4'd5,  RATIO_QUARTER, REPLY_ZERO,   1'b0, 8'h00, 32'h0},
        '{4'd5,  RATIO_KEEP,    REPLY_ZERO,   1'b0, 8'h00, 32'h0},
        '{4'd3,  RATIO_HALF,    REPLY_NONE,   1'b1, 8'h00, 32'h0},
        '{4'd9,  RATIO_DOUBLE,  REPLY_NONE,   1'b1, 8'h00, 32'h0},
        '{4'd3,  RATIO_KEEP,    REPLY_CACHED, 1'b1, 8'h00, 32'h0},
        '{4'd12, RATIO_QUARTER, REPLY_NONE,   1'b1, 8'h00, 32'h0},
        '{4'd9,  RATIO_KEEP,    REPLY_CACHED, 1'b1, 8'h00, 32'h0}
    };

    logic        clk           = 1'b0;
    logic        rst_n         = 1'b0;
    logic        in_valid      = 1'b0;
    pic_id_t     in_pic_no     = '0;
    ratio_e      in_ratio_mode = RATIO_KEEP;
    logic        rd_req_ready  = 1'b0;
    logic        rd_valid      = 1'b0;
    beat_t       rd_data       = '0;
    logic        wr_ready      = 1'b0;
    logic        out_valid;
    pixel_t      out_data;
    logic        rd_req_valid;
    logic [31:0] rd_addr;
    logic        rd_ready;
    logic        wr_valid;
    beat_t       wr_data;
    logic        wr_last;

    beat_t       mem [NUM_BEATS];
    beat_t       ref_mem [NUM_BEATS];
    int          cyc         = 0;
    logic        stall_en    = 1'b0;
    logic        expect_read = 1'b0;
    logic [31:0] exp_addr    = '0;
    ratio_e      cur_ratio   = RATIO_KEEP;
    int          req_total   = 0;
    logic        rd_open     = 1'b0;
    int          rd_idx      = 0;
    int          wr_idx      = 0;
    int          base_beat   = 0;

    isp_top #(
        .NUM_PICS   (NUM_PICS),
        .BASE_ADDR  (BASE_ADDR),
        .PIC_STRIDE (PIC_STRIDE)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .rd_req_valid  (rd_req_valid),
        .rd_addr       (rd_addr),
        .rd_req_ready  (rd_req_ready),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_ready      (rd_ready),
        .wr_valid      (wr_valid),
        .wr_data       (wr_data),
        .wr_last       (wr_last),
        .wr_ready      (wr_ready)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // checks
    // ------------------------------
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_pixel(string name, pixel_t got, pixel_t exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%02h, expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_beat(string name, beat_t got, beat_t exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%032h, expected 0x%032h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic pixel_t ref_scale(pixel_t p, ratio_e r);
        int v;
        v = int'(p);
        case (r)
            RATIO_QUARTER: v = v / 4;
            RATIO_HALF:    v = v / 2;
            RATIO_KEEP:    v = v;
            default:       v = (2 * v > 255) ? 255 : 2 * v;
        endcase
        return pixel_t'(v);
    endfunction

    function automatic beat_t scale_beat(beat_t b, ratio_e r);
        beat_t res;
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            res[i].value = ref_scale(b[i].value, r);
        end
        return res;
    endfunction

    task automatic build_expected();
        expo_cnt_t cnt [NUM_PICS];
        logic      cached [NUM_PICS];
        pixel_t    cache_avg [NUM_PICS];
        int        p;
        int        r;
        int        c;
        int        sum;
        int        base;
        pixel_t    s;
        reply_e    kind;
        for (int i = 0; i < NUM_PICS; i++) begin
            cnt[i]       = EXPO_CNT_MAX;
            cached[i]    = 1'b0;
            cache_avg[i] = '0;
        end
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            p = int'(tbl[e].pic);
            r = int'(tbl[e].ratio);
            c = int'(cnt[p]);
            tbl[e].addr = BASE_ADDR + 32'(p * PIC_STRIDE);
            if (c == 0 || (c == 1 && r <= 1) || (c == 2 && r == 0)) begin
                kind       = REPLY_ZERO;
                tbl[e].avg = '0;
            end else if (r == 2 && cached[p]) begin
                kind       = REPLY_CACHED;
                tbl[e].avg = cache_avg[p];
            end else begin
                kind = REPLY_NONE;
                sum  = 0;
                base = p * BEATS_PER_PIC;
                for (int b = 0; b < BEATS_PER_PIC; b++) begin
                    for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
                        s = ref_scale(ref_mem[base + b][i].value, tbl[e].ratio);
                        ref_mem[base + b][i].value = s;
                        // green at half weight
                        if (b / BEATS_PER_CHANNEL == 1) begin
                            sum += int'(s) >> 1;
                        end else begin
                            sum += int'(s) >> 2;
                        end
                    end
                end
                tbl[e].avg   = pixel_t'(sum >> AVG_SHIFT);
                cached[p]    = 1'b1;
                cache_avg[p] = tbl[e].avg;
            end
            if (c != 0) begin
                c = c - 2 + r;
                c = (c < 0) ? 0 : ((c > 8) ? 8 : c);
                cnt[p] = expo_cnt_t'(c);
            end
            if (kind != tbl[e].kind) begin
                $display("table entry %0d has a reply kind the counter rules do not give", e);
                abort_run();
            end
        end
    endtask

    // ------------------------------
    // memory model
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_req_valid && rd_req_ready) begin
                if (!expect_read) begin
                    $display("read request issued for a request that needs no read");
                    abort_run();
                end
                check_addr("rd_addr", rd_addr, exp_addr);
                base_beat = int'((rd_addr - BASE_ADDR) / 16);
                rd_idx    = 0;
                wr_idx    = 0;
                rd_open   = 1'b1;
                req_total++;
            end
            if (rd_valid && rd_ready) begin
                rd_idx++;
                if (rd_idx == BEATS_PER_PIC) begin
                    rd_open = 1'b0;
                end
            end
            // mem still holds the read value of this beat
            if (wr_valid && wr_ready) begin
                check_beat("wr_data", wr_data, scale_beat(mem[base_beat + wr_idx], cur_ratio));
                check_flag("wr_last", wr_last, wr_idx == BEATS_PER_PIC - 1);
                mem[base_beat + wr_idx] = wr_data;
                wr_idx++;
            end
            rd_req_ready <= !stall_en || ($urandom % 4 != 0);
            wr_ready     <= !stall_en || ($urandom % 4 != 0);
            if (rd_open) begin
                rd_valid <= !stall_en || ($urandom % 4 != 0);
                rd_data  <= mem[base_beat + rd_idx];
            end else begin
                rd_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout, run went past %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic run_entry(int e);
        int start_edge;
        int waited;
        int req_before;
        stall_en    = tbl[e].stall;
        expect_read = (tbl[e].kind == REPLY_NONE);
        exp_addr    = tbl[e].addr;
        cur_ratio   = tbl[e].ratio;
        req_before  = req_total;
        in_valid      <= 1'b1;
        in_pic_no     <= tbl[e].pic;
        in_ratio_mode <= tbl[e].ratio;
        @(posedge clk);
        in_valid   <= 1'b0;
        start_edge = cyc;
        waited     = 0;
        @(posedge clk);
        while (!out_valid) begin
            waited++;
            if (waited > REPLY_WAIT) begin
                $display("no reply for request %0d", e);
                abort_run();
            end
            @(posedge clk);
        end
        check_pixel("out_data", out_data, tbl[e].avg);
        // seen here, set one edge earlier
        if (tbl[e].kind != REPLY_NONE && cyc - 1 - start_edge != 2) begin
            $display("shortcut reply for request %0d not two cycles after in_valid", e);
            abort_run();
        end
        if (tbl[e].kind == REPLY_NONE &&
            (req_total - req_before != 1 || wr_idx != BEATS_PER_PIC)) begin
            $display("request %0d did not read and write back one whole picture", e);
            abort_run();
        end
        @(posedge clk);
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hbc5));
        for (int b = 0; b < NUM_BEATS; b++) begin
            mem[b] = {$urandom, $urandom, $urandom, $urandom};
        end
        ref_mem = mem;
        build_expected();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("rd_req_valid", rd_req_valid, 1'b0);
        check_flag("rd_ready", rd_ready, 1'b0);
        check_flag("wr_valid", wr_valid, 1'b0);

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verilog.f
source/isp_pixel_pkg.sv
source/isp_ctrl_pkg.sv
source/exposure_job_if.sv
source/isp_request_decode.sv
source/isp_exposure_datapath.sv
source/isp_result_store.sv
source/isp_top.sv
sim/isp_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= isp_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
